// File: source/rsv_macros.svh
`ifndef RSV_MACROS_SVH
`define RSV_MACROS_SVH

// table geometry
`define RSV_ENTRY_NUMS      16
`define RSV_IDX_WIDTH       4

// physical register tag
`define PRF_CODE_WIDTH      6

// dispatch lanes into the table
`define RSV_DSP_LANES       2

// writeback broadcast lanes
`define RSV_WB_LANES        2

// issue read ports
`define RSV_ISSUE_PORTS     2

`endif

// File: source/rsv_src_pkg.sv
`include "rsv_macros.svh"

package rsv_src_pkg;

    // physical register tag, register zero is always available
    typedef logic [`PRF_CODE_WIDTH - 1 : 0] prf_code_t;

    // index of one reservation entry
    typedef logic [`RSV_IDX_WIDTH - 1 : 0] rsv_idx_t;

    // one bit per entry
    // used for oldest vectors, write enables, valid and ready
    typedef logic [`RSV_ENTRY_NUMS - 1 : 0] rsv_vec_t;

endpackage

// File: source/rsv_src_alloc.sv
`timescale 1ns/1ns

`include "rsv_macros.svh"

module rsv_src_alloc (
    input  logic                    i_csr_trap_flush,
    input  logic                    i_exu_mis_flush,
    input  logic                    i_exu_ls_flush,
    input  logic                    i_arb_stall,

    input  logic                    i_dsp_vld        [`RSV_DSP_LANES],
    input  rsv_src_pkg::rsv_idx_t   i_dsp_free_entry [`RSV_DSP_LANES],
    input  logic                    i_dsp_src_vld    [`RSV_DSP_LANES],
    input  rsv_src_pkg::prf_code_t  i_dsp_prf_code   [`RSV_DSP_LANES],

    output logic                    o_dsp_rdy,
    output logic                    o_flush,
    output rsv_src_pkg::rsv_vec_t   o_wr_en,
    output rsv_src_pkg::prf_code_t  o_wr_prf_code [`RSV_ENTRY_NUMS],
    output rsv_src_pkg::rsv_vec_t   o_wr_src_vld,
    output rsv_src_pkg::rsv_vec_t   o_wr_init_rdy
);

    import rsv_src_pkg::*;

    logic [`RSV_DSP_LANES - 1 : 0] lane_acc;
    logic [`RSV_DSP_LANES - 1 : 0] lane_init_rdy;

    assign o_flush   = i_csr_trap_flush | i_exu_mis_flush | i_exu_ls_flush;
    assign o_dsp_rdy = ~i_arb_stall & ~o_flush;

    // ready at once with no source or with register zero
    always_comb begin
        for (int l = 0; l < `RSV_DSP_LANES; l++) begin
            lane_acc[l]      = i_dsp_vld[l] & o_dsp_rdy;
            lane_init_rdy[l] = ~i_dsp_src_vld[l] | (i_dsp_prf_code[l] == '0);
        end
    end

    // lanes name distinct entries, so an OR of the hits is the mux
    always_comb begin
        for (int e = 0; e < `RSV_ENTRY_NUMS; e++) begin
            o_wr_en[e]       = 1'b0;
            o_wr_prf_code[e] = '0;
            o_wr_src_vld[e]  = 1'b0;
            o_wr_init_rdy[e] = 1'b0;
            for (int l = 0; l < `RSV_DSP_LANES; l++) begin
                if (lane_acc[l] && (i_dsp_free_entry[l] == rsv_idx_t'(e))) begin
                    o_wr_en[e]       = 1'b1;
                    o_wr_prf_code[e] = o_wr_prf_code[e] | i_dsp_prf_code[l];
                    o_wr_src_vld[e]  = o_wr_src_vld[e] | i_dsp_src_vld[l];
                    o_wr_init_rdy[e] = o_wr_init_rdy[e] | lane_init_rdy[l];
                end
            end
        end
    end

    // the free list upstream must never hand one entry to two lanes
    always_comb begin
        for (int a = 0; a < `RSV_DSP_LANES; a++) begin
            for (int b = a + 1; b < `RSV_DSP_LANES; b++) begin
                assert final (!(lane_acc[a] && lane_acc[b]
                                && (i_dsp_free_entry[a] == i_dsp_free_entry[b])))
                else
                    $error("dispatch lanes %0d and %0d both target entry %0d",
                           a, b, i_dsp_free_entry[a]);
            end
        end
    end

endmodule

// File: source/rsv_src_table.sv
`timescale 1ns/1ns

`include "rsv_macros.svh"

module rsv_src_table (
    input  logic                    clk,
    input  logic                    i_rst_n,

    input  logic                    i_flush,
    input  rsv_src_pkg::rsv_vec_t   i_wr_en,
    input  rsv_src_pkg::prf_code_t  i_wr_prf_code [`RSV_ENTRY_NUMS],
    input  rsv_src_pkg::rsv_vec_t   i_wr_src_vld,
    input  rsv_src_pkg::rsv_vec_t   i_wr_init_rdy,

    input  logic                    i_wb_vld      [`RSV_WB_LANES],
    input  rsv_src_pkg::prf_code_t  i_wb_prf_code [`RSV_WB_LANES],

    output rsv_src_pkg::rsv_vec_t   o_src_vld,
    output rsv_src_pkg::prf_code_t  o_src_prf_code [`RSV_ENTRY_NUMS],
    output rsv_src_pkg::rsv_vec_t   o_src_rdy
);

    import rsv_src_pkg::*;

    rsv_vec_t  src_vld_r;
    rsv_vec_t  src_rdy_r;
    prf_code_t src_prf_code_r [`RSV_ENTRY_NUMS];

    rsv_vec_t  wb_hit;
    rsv_vec_t  src_vld_nxt;
    rsv_vec_t  src_rdy_nxt;

    // wakeup compare, every stored tag against every writeback tag
    always_comb begin
        for (int e = 0; e < `RSV_ENTRY_NUMS; e++) begin
            wb_hit[e] = 1'b0;
            for (int l = 0; l < `RSV_WB_LANES; l++) begin
                wb_hit[e] = wb_hit[e]
                          | (i_wb_vld[l] & (i_wb_prf_code[l] == src_prf_code_r[e]));
            end
        end
    end

    // flush, then dispatch, then wakeup, else hold
    always_comb begin
        if (i_flush) begin
            src_vld_nxt = '0;
            src_rdy_nxt = '0;
        end else begin
            src_vld_nxt = (i_wr_en & i_wr_src_vld) | (~i_wr_en & src_vld_r);
            src_rdy_nxt = (i_wr_en & i_wr_init_rdy)
                        | (~i_wr_en & (src_rdy_r | wb_hit));
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            src_vld_r <= '0;
            src_rdy_r <= '0;
        end else begin
            src_vld_r <= src_vld_nxt;
            src_rdy_r <= src_rdy_nxt;
        end
    end

    // tags survive a flush
    always_ff @(posedge clk) begin
        for (int e = 0; e < `RSV_ENTRY_NUMS; e++) begin
            if (!i_rst_n) begin
                src_prf_code_r[e] <= '0;
            end else if (i_wr_en[e]) begin
                src_prf_code_r[e] <= i_wr_prf_code[e];
            end
        end
    end

    assign o_src_vld      = src_vld_r;
    assign o_src_prf_code = src_prf_code_r;
    assign o_src_rdy      = src_rdy_r;

    // flush merged in alloc must leave nothing ready or valid
    a_flush_clears : assert property (
        @(posedge clk) disable iff (!i_rst_n)
        i_flush |=> ((o_src_rdy == '0) && (o_src_vld == '0))
    ) else
        $error("table not cleared after flush, rdy %h vld %h", o_src_rdy, o_src_vld);

endmodule

// File: source/rsv_src_issue_read.sv
`timescale 1ns/1ns

`include "rsv_macros.svh"

module rsv_src_issue_read (
    input  rsv_src_pkg::rsv_vec_t   i_issue_oldest_vec [`RSV_ISSUE_PORTS],
    input  rsv_src_pkg::rsv_vec_t   i_src_vld,
    input  rsv_src_pkg::prf_code_t  i_src_prf_code     [`RSV_ENTRY_NUMS],
    output logic                    o_issue_src_vld    [`RSV_ISSUE_PORTS],
    output rsv_src_pkg::prf_code_t  o_issue_prf_code   [`RSV_ISSUE_PORTS]
);

    import rsv_src_pkg::*;

    rsv_idx_t sel_idx [`RSV_ISSUE_PORTS];

    // one-hot to index by ORing the set bit positions
    always_comb begin
        for (int p = 0; p < `RSV_ISSUE_PORTS; p++) begin
            sel_idx[p] = '0;
            for (int e = 0; e < `RSV_ENTRY_NUMS; e++) begin
                if (i_issue_oldest_vec[p][e]) begin
                    sel_idx[p] = sel_idx[p] | rsv_idx_t'(e);
                end
            end
        end
    end

    // empty vector reads zeros
    always_comb begin
        for (int p = 0; p < `RSV_ISSUE_PORTS; p++) begin
            if (|i_issue_oldest_vec[p]) begin
                o_issue_src_vld[p]  = i_src_vld[sel_idx[p]];
                o_issue_prf_code[p] = i_src_prf_code[sel_idx[p]];
            end else begin
                o_issue_src_vld[p]  = 1'b0;
                o_issue_prf_code[p] = '0;
            end
        end
    end

    // age matrix upstream selects at most one entry per port
    always_comb begin
        for (int p = 0; p < `RSV_ISSUE_PORTS; p++) begin
            assert final ($onehot0(i_issue_oldest_vec[p]))
            else
                $error("issue port %0d oldest vector not one-hot: %h",
                       p, i_issue_oldest_vec[p]);
        end
    end

endmodule

// File: source/rsv_src_top.sv
`timescale 1ns/1ns

`include "rsv_macros.svh"

module rsv_src_top (
    input  logic                    clk,
    input  logic                    i_rst_n,

    input  logic                    i_csr_trap_flush,
    input  logic                    i_exu_mis_flush,
    input  logic                    i_exu_ls_flush,
    input  logic                    i_arb_stall,

    input  logic                    i_dsp_vld        [`RSV_DSP_LANES],
    input  rsv_src_pkg::rsv_idx_t   i_dsp_free_entry [`RSV_DSP_LANES],
    input  logic                    i_dsp_src_vld    [`RSV_DSP_LANES],
    input  rsv_src_pkg::prf_code_t  i_dsp_prf_code   [`RSV_DSP_LANES],
    output logic                    o_dsp_rdy,

    input  logic                    i_wb_vld         [`RSV_WB_LANES],
    input  rsv_src_pkg::prf_code_t  i_wb_prf_code    [`RSV_WB_LANES],

    input  rsv_src_pkg::rsv_vec_t   i_issue_oldest_vec [`RSV_ISSUE_PORTS],
    output logic                    o_issue_src_vld    [`RSV_ISSUE_PORTS],
    output rsv_src_pkg::prf_code_t  o_issue_prf_code   [`RSV_ISSUE_PORTS],

    output rsv_src_pkg::rsv_vec_t   o_src_rdy
);

    // per entry write data from dispatch
    logic                   flush;
    rsv_src_pkg::rsv_vec_t  wr_en;
    rsv_src_pkg::prf_code_t wr_prf_code [`RSV_ENTRY_NUMS];
    rsv_src_pkg::rsv_vec_t  wr_src_vld;
    rsv_src_pkg::rsv_vec_t  wr_init_rdy;

    // registered table state
    rsv_src_pkg::rsv_vec_t  src_vld;
    rsv_src_pkg::prf_code_t src_prf_code [`RSV_ENTRY_NUMS];

    rsv_src_alloc alloc_i (
        .i_csr_trap_flush   (i_csr_trap_flush),
        .i_exu_mis_flush    (i_exu_mis_flush),
        .i_exu_ls_flush     (i_exu_ls_flush),
        .i_arb_stall        (i_arb_stall),
        .i_dsp_vld          (i_dsp_vld),
        .i_dsp_free_entry   (i_dsp_free_entry),
        .i_dsp_src_vld      (i_dsp_src_vld),
        .i_dsp_prf_code     (i_dsp_prf_code),
        .o_dsp_rdy          (o_dsp_rdy),
        .o_flush            (flush),
        .o_wr_en            (wr_en),
        .o_wr_prf_code      (wr_prf_code),
        .o_wr_src_vld       (wr_src_vld),
        .o_wr_init_rdy      (wr_init_rdy)
    );

    rsv_src_table table_i (
        .clk                (clk),
        .i_rst_n            (i_rst_n),
        .i_flush            (flush),
        .i_wr_en            (wr_en),
        .i_wr_prf_code      (wr_prf_code),
        .i_wr_src_vld       (wr_src_vld),
        .i_wr_init_rdy      (wr_init_rdy),
        .i_wb_vld           (i_wb_vld),
        .i_wb_prf_code      (i_wb_prf_code),
        .o_src_vld          (src_vld),
        .o_src_prf_code     (src_prf_code),
        .o_src_rdy          (o_src_rdy)
    );

    rsv_src_issue_read issue_read_i (
        .i_issue_oldest_vec (i_issue_oldest_vec),
        .i_src_vld          (src_vld),
        .i_src_prf_code     (src_prf_code),
        .o_issue_src_vld    (o_issue_src_vld),
        .o_issue_prf_code   (o_issue_prf_code)
    );

endmodule

// File: tests/tb_rsv_src.sv
`timescale 1ns/1ns

`include "rsv_macros.svh"

module tb_rsv_src;

    import rsv_src_pkg::*;

    // directed part plus the random run rounded up
    localparam int TEST_CYCLES   = 500;
    localparam int CYCLE_LIMIT   = 4 * TEST_CYCLES;
    localparam int RANDOM_CYCLES = 400;

    logic      clk;
    logic      rst_n;
    logic      csr_trap_flush;
    logic      exu_mis_flush;
    logic      exu_ls_flush;
    logic      arb_stall;
    logic      dsp_vld        [`RSV_DSP_LANES];
    rsv_idx_t  dsp_free_entry [`RSV_DSP_LANES];
    logic      dsp_src_vld    [`RSV_DSP_LANES];
    prf_code_t dsp_prf_code   [`RSV_DSP_LANES];
    logic      dsp_rdy;
    logic      wb_vld         [`RSV_WB_LANES];
    prf_code_t wb_prf_code    [`RSV_WB_LANES];
    rsv_vec_t  oldest_vec     [`RSV_ISSUE_PORTS];
    logic      issue_src_vld  [`RSV_ISSUE_PORTS];
    prf_code_t issue_prf_code [`RSV_ISSUE_PORTS];
    rsv_vec_t  src_rdy;

    // reference model of the table
    rsv_vec_t  m_vld;
    rsv_vec_t  m_rdy;
    prf_code_t m_tag [`RSV_ENTRY_NUMS];
    logic      exp_dsp_rdy;
    logic      exp_iss_vld  [`RSV_ISSUE_PORTS];
    prf_code_t exp_iss_code [`RSV_ISSUE_PORTS];

    logic [31:0] lcg_state    = 32'h6eef90cb;
    int          mismatch_cnt = 0;
    int          other_cnt    = 0;
    int          cycle_cnt    = 0;

    rsv_src_top dut_i (
        .clk                (clk),
        .i_rst_n            (rst_n),
        .i_csr_trap_flush   (csr_trap_flush),
        .i_exu_mis_flush    (exu_mis_flush),
        .i_exu_ls_flush     (exu_ls_flush),
        .i_arb_stall        (arb_stall),
        .i_dsp_vld          (dsp_vld),
        .i_dsp_free_entry   (dsp_free_entry),
        .i_dsp_src_vld      (dsp_src_vld),
        .i_dsp_prf_code     (dsp_prf_code),
        .o_dsp_rdy          (dsp_rdy),
        .i_wb_vld           (wb_vld),
        .i_wb_prf_code      (wb_prf_code),
        .i_issue_oldest_vec (oldest_vec),
        .o_issue_src_vld    (issue_src_vld),
        .o_issue_prf_code   (issue_prf_code),
        .o_src_rdy          (src_rdy)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // upper bits of the LCG are the better ones
    function automatic int rand_below(input int n);
        return int'((next_rand() >> 16) % n);
    endfunction

    function automatic int oldest_index(input rsv_vec_t vec);
        int idx;
        idx = -1;
        for (int e = 0; e < `RSV_ENTRY_NUMS; e++) begin
            if (vec[e]) begin
                idx = e;
            end
        end
        return idx;
    endfunction

    // model update with flush over dispatch over wakeup
    always @(posedge clk) begin
        logic flush_any;
        logic hit;
        logic acc;
        flush_any = csr_trap_flush | exu_mis_flush | exu_ls_flush;
        if (!rst_n) begin
            m_vld <= '0;
            m_rdy <= '0;
            for (int e = 0; e < `RSV_ENTRY_NUMS; e++) begin
                m_tag[e] <= '0;
            end
        end else if (flush_any) begin
            m_vld <= '0;
            m_rdy <= '0;
        end else begin
            for (int e = 0; e < `RSV_ENTRY_NUMS; e++) begin
                hit = 1'b0;
                acc = 1'b0;
                for (int w = 0; w < `RSV_WB_LANES; w++) begin
                    if (wb_vld[w] && (wb_prf_code[w] == m_tag[e])) begin
                        hit = 1'b1;
                    end
                end
                for (int l = 0; l < `RSV_DSP_LANES; l++) begin
                    if (dsp_vld[l] && !arb_stall && (int'(dsp_free_entry[l]) == e)) begin
                        acc = 1'b1;
                        m_tag[e] <= dsp_prf_code[l];
                        m_vld[e] <= dsp_src_vld[l];
                        m_rdy[e] <= !dsp_src_vld[l] || (dsp_prf_code[l] == '0);
                    end
                end
                if (!acc && hit) begin
                    m_rdy[e] <= 1'b1;
                end
            end
        end
    end

    always_comb begin
        int sel;
        exp_dsp_rdy = !(arb_stall || csr_trap_flush || exu_mis_flush || exu_ls_flush);
        for (int p = 0; p < `RSV_ISSUE_PORTS; p++) begin
            sel = oldest_index(oldest_vec[p]);
            if (sel < 0) begin
                exp_iss_vld[p]  = 1'b0;
                exp_iss_code[p] = '0;
            end else begin
                exp_iss_vld[p]  = m_vld[rsv_idx_t'(sel)];
                exp_iss_code[p] = m_tag[rsv_idx_t'(sel)];
            end
        end
    end

    a_dsp_rdy : assert property (@(posedge clk) disable iff (!rst_n) dsp_rdy == exp_dsp_rdy)
    else begin
        mismatch_cnt = mismatch_cnt + 1;
        $display("mismatch o_dsp_rdy: dut %h model %h", $sampled(dsp_rdy), $sampled(exp_dsp_rdy));
    end

    a_src_rdy : assert property (@(posedge clk) disable iff (!rst_n) src_rdy == m_rdy)
    else begin
        mismatch_cnt = mismatch_cnt + 1;
        $display("mismatch o_src_rdy: dut %h model %h", $sampled(src_rdy), $sampled(m_rdy));
    end

    for (genvar p = 0; p < `RSV_ISSUE_PORTS; p++) begin : g_issue_chk
        a_iss_vld : assert property (@(posedge clk) disable iff (!rst_n)
                                     issue_src_vld[p] == exp_iss_vld[p])
        else begin
            mismatch_cnt = mismatch_cnt + 1;
            $display("mismatch o_issue_src_vld[%0d]: dut %h model %h", p,
                     $sampled(issue_src_vld[p]), $sampled(exp_iss_vld[p]));
        end

        a_iss_code : assert property (@(posedge clk) disable iff (!rst_n)
                                      issue_prf_code[p] == exp_iss_code[p])
        else begin
            mismatch_cnt = mismatch_cnt + 1;
            $display("mismatch o_issue_prf_code[%0d]: dut %h model %h", p,
                     $sampled(issue_prf_code[p]), $sampled(exp_iss_code[p]));
        end
    end

    task automatic tick();
        @(negedge clk);
    endtask

    task automatic idle_inputs();
        csr_trap_flush = 1'b0;
        exu_mis_flush  = 1'b0;
        exu_ls_flush   = 1'b0;
        arb_stall      = 1'b0;
        for (int l = 0; l < `RSV_DSP_LANES; l++) begin
            dsp_vld[l]        = 1'b0;
            dsp_free_entry[l] = '0;
            dsp_src_vld[l]    = 1'b0;
            dsp_prf_code[l]   = '0;
        end
        for (int w = 0; w < `RSV_WB_LANES; w++) begin
            wb_vld[w]      = 1'b0;
            wb_prf_code[w] = '0;
        end
        for (int p = 0; p < `RSV_ISSUE_PORTS; p++) begin
            oldest_vec[p] = '0;
        end
    endtask

    task automatic dispatch_lane(input int lane, input int entry, input logic src_vld,
                                 input int code);
        dsp_vld[lane]        = 1'b1;
        dsp_free_entry[lane] = rsv_idx_t'(entry);
        dsp_src_vld[lane]    = src_vld;
        dsp_prf_code[lane]   = prf_code_t'(code);
    endtask

    task automatic writeback_lane(input int lane, input int code);
        wb_vld[lane]      = 1'b1;
        wb_prf_code[lane] = prf_code_t'(code);
    endtask

    task automatic set_oldest(input int port, input int entry);
        oldest_vec[port] = rsv_vec_t'(1) << entry;
    endtask

    task automatic raise_flush(input int src);
        case (src)
            0:       csr_trap_flush = 1'b1;
            1:       exu_mis_flush  = 1'b1;
            default: exu_ls_flush   = 1'b1;
        endcase
    endtask

    task automatic random_inputs();
        int base;
        int spread;
        idle_inputs();
        // lane l takes base + l * spread, which keeps lanes on distinct entries
        base   = rand_below(`RSV_ENTRY_NUMS);
        spread = 1 + rand_below(`RSV_ENTRY_NUMS / `RSV_DSP_LANES);
        for (int l = 0; l < `RSV_DSP_LANES; l++) begin
            if (rand_below(4) != 0) begin
                dispatch_lane(l, (base + l * spread) % `RSV_ENTRY_NUMS,
                              rand_below(8) != 0, rand_below(16));
            end
        end
        for (int w = 0; w < `RSV_WB_LANES; w++) begin
            if (rand_below(2) != 0) begin
                writeback_lane(w, rand_below(16));
            end
        end
        arb_stall      = (rand_below(8) == 0);
        csr_trap_flush = (rand_below(32) == 0);
        exu_mis_flush  = (rand_below(32) == 0);
        exu_ls_flush   = (rand_below(32) == 0);
        for (int p = 0; p < `RSV_ISSUE_PORTS; p++) begin
            if (rand_below(3) != 0) begin
                set_oldest(p, rand_below(`RSV_ENTRY_NUMS));
            end
        end
    endtask

    task automatic print_summary();
        $display("errors: %0d mismatch, %0d other", mismatch_cnt, other_cnt);
    endtask

    initial begin
        rst_n = 1'b0;
        idle_inputs();
        repeat (10) @(posedge clk);
        tick();
        rst_n = 1'b1;
        set_oldest(0, 3);
        set_oldest(1, 7);
        repeat (2) tick();

        // tag zero ready at once, tag five waits, no source ready at once
        idle_inputs();
        dispatch_lane(0, 3, 1'b1, 0);
        dispatch_lane(1, 7, 1'b1, 5);
        set_oldest(0, 3);
        set_oldest(1, 7);
        tick();
        idle_inputs();
        dispatch_lane(0, 9, 1'b0, 12);
        dispatch_lane(1, 10, 1'b1, 5);
        set_oldest(0, 9);
        set_oldest(1, 10);
        tick();
        idle_inputs();
        dispatch_lane(0, 11, 1'b1, 9);
        dispatch_lane(1, 12, 1'b1, 9);
        set_oldest(0, 7);
        set_oldest(1, 10);
        tick();

        // wakeup on each writeback lane
        idle_inputs();
        writeback_lane(0, 5);
        dispatch_lane(0, 13, 1'b1, 20);
        set_oldest(0, 11);
        set_oldest(1, 12);
        tick();
        idle_inputs();
        writeback_lane(1, 9);
        set_oldest(0, 7);
        set_oldest(1, 13);
        tick();

        // dispatch and wakeup on entry 13 together
        idle_inputs();
        dispatch_lane(0, 13, 1'b1, 22);
        writeback_lane(1, 20);
        set_oldest(0, 13);
        tick();
        idle_inputs();
        set_oldest(0, 13);
        set_oldest(1, 11);
        tick();

        // stalled dispatch held for two cycles while wakeup still lands
        idle_inputs();
        arb_stall = 1'b1;
        dispatch_lane(0, 0, 1'b1, 30);
        dispatch_lane(1, 13, 1'b1, 0);
        writeback_lane(0, 22);
        set_oldest(0, 0);
        set_oldest(1, 13);
        repeat (2) tick();
        // request still held when the stall drops
        arb_stall = 1'b0;
        tick();
        idle_inputs();
        set_oldest(0, 0);
        set_oldest(1, 13);
        tick();

        for (int f = 0; f < 3; f++) begin
            idle_inputs();
            dispatch_lane(0, 1 + f, 1'b1, 0);
            dispatch_lane(1, 4 + f, 1'b1, 7);
            tick();
            idle_inputs();
            raise_flush(f);
            dispatch_lane(0, 14, 1'b1, 0);
            set_oldest(0, 1 + f);
            set_oldest(1, 14);
            tick();
            idle_inputs();
            set_oldest(0, 14);
            set_oldest(1, 4 + f);
            tick();
        end

        repeat (RANDOM_CYCLES) begin
            random_inputs();
            tick();
        end

        idle_inputs();
        repeat (3) tick();
        print_summary();
        if (mismatch_cnt == 0 && other_cnt == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin
        while (cycle_cnt < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_cnt = cycle_cnt + 1;
        end
        other_cnt = other_cnt + 1;
        $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        print_summary();
        $display(">>> FAIL");
        $finish;
    end

endmodule

// File: sources.f
+incdir+source
source/rsv_src_pkg.sv
source/rsv_src_alloc.sv
source/rsv_src_table.sv
source/rsv_src_issue_read.sv
source/rsv_src_top.sv
tests/tb_rsv_src.sv

// File: run.sh
#!/bin/sh
# compile and run the reservation station testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --assert --timing -f sources.f --top-module tb_rsv_src -Mdir "$BUILD_DIR"
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/Vtb_rsv_src" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^>>> PASS$" "$LOG"; then
    echo "simulation passed"
    exit 0
fi

echo "simulation failed, see $LOG"
exit 1
